// ==== Makefile ====
TOP := tb_compliance

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== compile.f ====
verilog/compliance_pkg.sv
verilog/bus_if.sv
verilog/bus_xbar.sv
verilog/ram_1p.sv
verilog/testutil_regs.sv
verilog/testutil_dumper.sv
verilog/compliance_top.sv
verification/compliance_checker.sv
verification/tb_compliance.sv

// ==== verification/compliance_checker.sv ====
// Concurrent checks on crossbar grants, response routing and the dump stream
// Bound into compliance_top; a granted host must see rvalid exactly one cycle later

`timescale 1ns/1ps
`default_nettype none

module compliance_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic ext_gnt_i,
  input logic tu_gnt_i,
  input logic ext_rvalid_i,
  input logic tu_rvalid_i,
  input logic done_i,
  input logic sig_valid_i
);

  int unsigned fail_count = 0;

  one_grant_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ext_gnt_i && tu_gnt_i))
    else begin
      $error("Both hosts granted in one cycle");
      fail_count++;
    end

  // Response routed back to the host that won the previous cycle
  ext_rsp_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_rvalid_i == $past(ext_gnt_i))
    else begin
      $error("External host rvalid does not follow its grant by one cycle");
      fail_count++;
    end

  tu_rsp_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tu_rvalid_i == $past(tu_gnt_i))
    else begin
      $error("Test utility host rvalid does not follow its grant by one cycle");
      fail_count++;
    end

  // Done is sticky until reset
  done_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |=> done_i)
    else begin
      $error("done fell without reset");
      fail_count++;
    end

  no_sig_after_done_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |-> !sig_valid_i)
    else begin
      $error("Signature word after done");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== verification/compliance_stim.txt ====
# Hex fields: W addr data be | R addr expected | E addr we | D addr expected | H
# E expects err with rdata zero; D checks the next dump word and the model word at addr
# Signature region 0x100 to 0x124, full words first
W 00000100 11111111 f
W 00000104 22222222 f
W 00000108 33333333 f
W 0000010c 44444444 f
W 00000110 a5a5a5a5 f
W 00000114 5a5a5a5a f
W 00000118 0badf00d f
W 0000011c deadbeef f
W 00000120 01234567 f
W 00000124 89abcdef f
W 00000200 cafef00d f
# Partial writes keep the lanes that are not enabled
W 00000104 aabbccdd 5
R 00000104 22bb22dd
W 00000108 99887766 c
R 00000108 99883333
W 00000110 00007700 2
R 00000110 a5a577a5
R 00000100 11111111
# Test utility bounds, halt status and a reserved offset
W 00020004 00000100 f
W 00020008 00000128 f
R 00020004 00000100
R 00020008 00000128
R 00020000 00000000
E 0002000c 0
# Unmapped address, read then write
E 00010000 0
E 00010000 1
# Start the dump, then external traffic and a second halt while it runs
W 00020000 00000001 f
R 00000200 cafef00d
W 00020000 00000001 f
R 00020000 00000001
D 00000100 11111111
D 00000104 22bb22dd
D 00000108 99883333
D 0000010c 44444444
D 00000110 a5a577a5
D 00000114 5a5a5a5a
D 00000118 0badf00d
D 0000011c deadbeef
D 00000120 01234567
D 00000124 89abcdef
H

// ==== verification/tb_compliance.sv ====
// Testbench for compliance_top, reads verification/compliance_stim.txt from the project root
// RAM words are compared only after a full-word write has defined them

`timescale 1ns/1ps
`default_nettype none

module tb_compliance;

  import compliance_pkg::*;

  localparam int Timeout = 200;

  logic        clk_i;
  logic        rst_n_i;
  logic        host_req_i;
  logic        host_gnt_o;
  logic [31:0] host_addr_i;
  logic        host_we_i;
  logic [3:0]  host_be_i;
  logic [31:0] host_wdata_i;
  logic        host_rvalid_o;
  logic [31:0] host_rdata_o;
  logic        host_err_o;
  logic        sig_valid_o;
  logic [31:0] sig_data_o;
  logic        done_o;

  // Reference RAM and the dump words seen so far
  logic [31:0] ref_mem [RamSizeWords];
  logic [31:0] sig_q [$];
  integer      seed;

  compliance_top compliance_top_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req_i),
    .host_gnt_o    (host_gnt_o),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .sig_valid_o   (sig_valid_o),
    .sig_data_o    (sig_data_o),
    .done_o        (done_o)
  );

  bind compliance_top compliance_checker u_checker (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ext_gnt_i    (ext_bus.gnt),
    .tu_gnt_i     (tu_host_bus.gnt),
    .ext_rvalid_i (ext_bus.rvalid),
    .tu_rvalid_i  (tu_host_bus.rvalid),
    .done_i       (done_o),
    .sig_valid_i  (sig_valid_o)
  );

  always #2 clk_i = ~clk_i;

  // Collect every dump word as it appears
  always @(posedge clk_i) begin
    if (rst_n_i && sig_valid_o) begin
      sig_q.push_back(sig_data_o);
    end
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // Stop at the first bound assertion failure
  always @(posedge clk_i) begin
    if (compliance_top_i.u_checker.fail_count != 0) begin
      fail_now("A bound assertion failed");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      fail_now($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic in_ram(input logic [31:0] addr);
    return (addr & RamMask) == RamBase;
  endfunction

  function automatic int unsigned ram_index(input logic [31:0] addr);
    return (addr & ~RamMask) >> 2;
  endfunction

  // One transfer on the external host port, request held until gnt
  task automatic bus_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int cycles;
    @(posedge clk_i);
    host_req_i   <= 1'b1;
    host_addr_i  <= addr;
    host_we_i    <= we;
    host_be_i    <= be;
    host_wdata_i <= wdata;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > Timeout) fail_now("Timeout waiting for host_gnt_o");
    end while (!host_gnt_o);
    host_req_i <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > Timeout) fail_now("Timeout waiting for host_rvalid_o");
    end while (!host_rvalid_o);
    rdata = host_rdata_o;
    err   = host_err_o;
  endtask

  initial begin
    int               fd;
    int               n;
    int               cycles;
    int               idle;
    logic [7:0]       op;
    logic [8*128-1:0] line;
    logic [31:0]      addr;
    logic [31:0]      data;
    logic [31:0]      exp_data;
    logic [3:0]       be;
    logic             we;
    logic [31:0]      rdata;
    logic             err;

    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    host_req_i   = 1'b0;
    host_addr_i  = 32'h0;
    host_we_i    = 1'b0;
    host_be_i    = 4'h0;
    host_wdata_i = 32'h0;
    seed         = 32'hd6b8;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    fd = $fopen("verification/compliance_stim.txt", "r");
    if (fd == 0) fail_now("Cannot open verification/compliance_stim.txt");
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        n = $fgets(line, fd);
      end else begin
        // Random gap before each operation
        idle = $unsigned($random(seed)) % 3;
        repeat (idle) @(posedge clk_i);
        case (op)
          "W": begin
            n = $fscanf(fd, "%h %h %h", addr, data, be);
            if (n != 3) fail_now("Malformed W line in stimulus file");
            bus_access(addr, 1'b1, be, data, rdata, err);
            check_value("host_err_o", {31'h0, err}, 32'h0);
            if (in_ram(addr)) begin
              for (int lane = 0; lane < 4; lane++) begin
                if (be[lane]) ref_mem[ram_index(addr)][lane*8 +: 8] = data[lane*8 +: 8];
              end
            end
          end
          "R": begin
            n = $fscanf(fd, "%h %h", addr, exp_data);
            if (n != 2) fail_now("Malformed R line in stimulus file");
            bus_access(addr, 1'b0, 4'hF, 32'h0, rdata, err);
            check_value("host_err_o", {31'h0, err}, 32'h0);
            if (in_ram(addr)) check_value("ref_mem", ref_mem[ram_index(addr)], exp_data);
            check_value("host_rdata_o", rdata, exp_data);
          end
          "E": begin
            n = $fscanf(fd, "%h %h", addr, we);
            if (n != 2) fail_now("Malformed E line in stimulus file");
            bus_access(addr, we, 4'hF, 32'h0, rdata, err);
            check_value("host_err_o", {31'h0, err}, 32'h1);
            check_value("host_rdata_o", rdata, 32'h0);
          end
          "D": begin
            n = $fscanf(fd, "%h %h", addr, exp_data);
            if (n != 2) fail_now("Malformed D line in stimulus file");
            check_value("ref_mem", ref_mem[ram_index(addr)], exp_data);
            cycles = 0;
            while (sig_q.size() == 0) begin
              @(posedge clk_i);
              cycles++;
              if (cycles > Timeout) fail_now("Timeout waiting for sig_valid_o");
            end
            check_value("sig_data_o", sig_q.pop_front(), exp_data);
          end
          "H": begin
            cycles = 0;
            while (!done_o) begin
              @(posedge clk_i);
              cycles++;
              if (cycles > Timeout) fail_now("Timeout waiting for done_o");
            end
            repeat (4) @(posedge clk_i);
            assert (sig_q.size() == 0) else begin
              fail_now($sformatf("Dump stream gave %0d words too many", sig_q.size()));
            end
          end
          default: fail_now($sformatf("Unknown operation %c in stimulus file", op));
        endcase
      end
    end
    $fclose(fd);

    if (compliance_top_i.u_checker.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", compliance_top_i.u_checker.fail_count);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bus_if.sv ====
// One req/gnt/rvalid link with a single outstanding request
// The host holds its request stable until gnt; rvalid follows the grant by one cycle

`timescale 1ns/1ps
`default_nettype none

interface bus_if;

  // Request side
  logic        req;
  logic        gnt;
  logic [31:0] addr;
  logic        we;
  logic [3:0]  be;
  logic [31:0] wdata;

  // Response side
  logic        rvalid;
  logic [31:0] rdata;
  logic        err;

  modport host (
    output req,
    output addr,
    output we,
    output be,
    output wdata,
    input  gnt,
    input  rvalid,
    input  rdata,
    input  err
  );

  modport device (
    input  req,
    input  addr,
    input  we,
    input  be,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata,
    output err
  );

endinterface

`default_nettype wire

// ==== verilog/bus_xbar.sv ====
// Two-host, two-device crossbar with fixed priority and base/mask decode
// Devices must accept in the request cycle and answer exactly one cycle later

`timescale 1ns/1ps
`default_nettype none

module bus_xbar (
  input  logic  clk_i,
  input  logic  rst_n_i,
  bus_if.device ext_host,
  bus_if.device tu_host,
  bus_if.host   ram_dev,
  bus_if.host   tu_dev
);

  import compliance_pkg::*;

  logic        h_req    [NrHosts];
  logic [31:0] h_addr   [NrHosts];
  logic        h_we     [NrHosts];
  logic [3:0]  h_be     [NrHosts];
  logic [31:0] h_wdata  [NrHosts];

  logic        d_req    [NrDevices];
  logic        d_gnt    [NrDevices];
  logic        d_rvalid [NrDevices];
  logic [31:0] d_rdata  [NrDevices];
  logic        d_err    [NrDevices];

  logic        any_req;
  bus_host_e   win;
  logic [31:0] sel_addr;
  logic        hit_ram;
  logic        hit_tu;
  logic        miss;
  bus_device_e sel_dev;
  logic        granted;

  logic        rsp_pend_q;
  bus_host_e   rsp_host_q;
  bus_device_e rsp_dev_q;
  logic        rsp_miss_q;
  logic        rsp_valid;
  logic [31:0] rsp_rdata;
  logic        rsp_err;

  // Gather host requests
  assign h_req[HostTestUtil]   = tu_host.req;
  assign h_addr[HostTestUtil]  = tu_host.addr;
  assign h_we[HostTestUtil]    = tu_host.we;
  assign h_be[HostTestUtil]    = tu_host.be;
  assign h_wdata[HostTestUtil] = tu_host.wdata;
  assign h_req[HostExt]        = ext_host.req;
  assign h_addr[HostExt]       = ext_host.addr;
  assign h_we[HostExt]         = ext_host.we;
  assign h_be[HostExt]         = ext_host.be;
  assign h_wdata[HostExt]      = ext_host.wdata;

  // Test utility host always wins
  assign any_req  = h_req[HostTestUtil] | h_req[HostExt];
  assign win      = h_req[HostTestUtil] ? HostTestUtil : HostExt;
  assign sel_addr = h_addr[win];

  assign hit_ram = (sel_addr & RamMask) == RamBase;
  assign hit_tu  = (sel_addr & TestUtilMask) == TestUtilBase;
  assign miss    = ~hit_ram & ~hit_tu;
  assign sel_dev = hit_ram ? DevRam : DevTestUtil;

  assign d_req[DevRam]      = any_req & hit_ram;
  assign d_req[DevTestUtil] = any_req & hit_tu & ~hit_ram;

  // A miss is granted here; a hit takes the device's own gnt
  assign granted = any_req & (miss | d_gnt[sel_dev]);

  // Forward the winning request to both devices, only one sees req
  assign ram_dev.req   = d_req[DevRam];
  assign ram_dev.addr  = sel_addr;
  assign ram_dev.we    = h_we[win];
  assign ram_dev.be    = h_be[win];
  assign ram_dev.wdata = h_wdata[win];
  assign tu_dev.req    = d_req[DevTestUtil];
  assign tu_dev.addr   = sel_addr;
  assign tu_dev.we     = h_we[win];
  assign tu_dev.be     = h_be[win];
  assign tu_dev.wdata  = h_wdata[win];

  assign d_gnt[DevRam]         = ram_dev.gnt;
  assign d_rvalid[DevRam]      = ram_dev.rvalid;
  assign d_rdata[DevRam]       = ram_dev.rdata;
  assign d_err[DevRam]         = ram_dev.err;
  assign d_gnt[DevTestUtil]    = tu_dev.gnt;
  assign d_rvalid[DevTestUtil] = tu_dev.rvalid;
  assign d_rdata[DevTestUtil]  = tu_dev.rdata;
  assign d_err[DevTestUtil]    = tu_dev.err;

  // Remember who owns next cycle's response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_pend_q <= 1'b0;
      rsp_host_q <= HostTestUtil;
      rsp_dev_q  <= DevRam;
      rsp_miss_q <= 1'b0;
    end else begin
      rsp_pend_q <= granted;
      if (granted) begin
        rsp_host_q <= win;
        rsp_dev_q  <= sel_dev;
        rsp_miss_q <= miss;
      end
    end
  end

  assign rsp_valid = rsp_pend_q & (rsp_miss_q | d_rvalid[rsp_dev_q]);
  assign rsp_rdata = rsp_miss_q ? 32'h0 : d_rdata[rsp_dev_q];
  assign rsp_err   = rsp_miss_q | d_err[rsp_dev_q];

  assign tu_host.gnt     = granted & (win == HostTestUtil);
  assign tu_host.rvalid  = rsp_valid & (rsp_host_q == HostTestUtil);
  assign tu_host.rdata   = rsp_rdata;
  assign tu_host.err     = rsp_err;
  assign ext_host.gnt    = granted & (win == HostExt);
  assign ext_host.rvalid = rsp_valid & (rsp_host_q == HostExt);
  assign ext_host.rdata  = rsp_rdata;
  assign ext_host.err    = rsp_err;

endmodule

`default_nettype wire

// ==== verilog/compliance_pkg.sv ====
// Shared constants and types for the compliance bus subsystem
// The RAM size must stay a power of two, since decode uses base/mask pairs

`default_nettype none

package compliance_pkg;

  // Bus hosts, in decreasing priority
  typedef enum logic [0:0] {
    HostTestUtil = 1'b0,
    HostExt      = 1'b1
  } bus_host_e;

  typedef enum logic [0:0] {
    DevRam      = 1'b0,
    DevTestUtil = 1'b1
  } bus_device_e;

  localparam int NrHosts   = 2;
  localparam int NrDevices = 2;

  // 4 kB of RAM
  localparam int unsigned RamSizeWords = 1024;

  // Address map
  localparam logic [31:0] RamBase      = 32'h0000_0000;
  localparam logic [31:0] RamMask      = ~32'(RamSizeWords * 4 - 1);
  localparam logic [31:0] TestUtilBase = 32'h0002_0000;
  localparam logic [31:0] TestUtilMask = ~32'h0000_03FF;

  // Test utility register byte offsets
  typedef enum logic [7:0] {
    RegHalt     = 8'h00,
    RegSigBegin = 8'h04,
    RegSigEnd   = 8'h08
  } tu_reg_e;

  // Signature dumper FSM
  typedef enum logic [1:0] {
    DumpIdle = 2'd0,
    DumpReq  = 2'd1,
    DumpWait = 2'd2,
    DumpDone = 2'd3
  } dump_state_e;

endpackage

`default_nettype wire

// ==== verilog/compliance_top.sv ====
// Compliance bus subsystem top: external host, crossbar, RAM and test utility
// The external host port follows the req/gnt/rvalid protocol, one request in flight

`timescale 1ns/1ps
`default_nettype none

module compliance_top (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        host_req_i,
  output logic        host_gnt_o,
  input  logic [31:0] host_addr_i,
  input  logic        host_we_i,
  input  logic [3:0]  host_be_i,
  input  logic [31:0] host_wdata_i,
  output logic        host_rvalid_o,
  output logic [31:0] host_rdata_o,
  output logic        host_err_o,
  output logic        sig_valid_o,
  output logic [31:0] sig_data_o,
  output logic        done_o
);

  import compliance_pkg::*;

  bus_if ext_bus ();
  bus_if tu_host_bus ();
  bus_if ram_bus ();
  bus_if tu_dev_bus ();

  logic        dump_start;
  logic        dump_busy;
  logic [31:0] sig_begin;
  logic [31:0] sig_end;

  // External host port onto its bus link
  assign ext_bus.req   = host_req_i;
  assign ext_bus.addr  = host_addr_i;
  assign ext_bus.we    = host_we_i;
  assign ext_bus.be    = host_be_i;
  assign ext_bus.wdata = host_wdata_i;
  assign host_gnt_o    = ext_bus.gnt;
  assign host_rvalid_o = ext_bus.rvalid;
  assign host_rdata_o  = ext_bus.rdata;
  assign host_err_o    = ext_bus.err;

  bus_xbar u_xbar (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .ext_host (ext_bus),
    .tu_host  (tu_host_bus),
    .ram_dev  (ram_bus),
    .tu_dev   (tu_dev_bus)
  );

  ram_1p #(
    .Depth (RamSizeWords)
  ) u_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (ram_bus)
  );

  testutil_regs u_testutil_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus         (tu_dev_bus),
    .busy_i      (dump_busy),
    .start_o     (dump_start),
    .sig_begin_o (sig_begin),
    .sig_end_o   (sig_end)
  );

  testutil_dumper u_testutil_dumper (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus         (tu_host_bus),
    .start_i     (dump_start),
    .sig_begin_i (sig_begin),
    .sig_end_i   (sig_end),
    .busy_o      (dump_busy),
    .sig_valid_o (sig_valid_o),
    .sig_data_o  (sig_data_o),
    .done_o      (done_o)
  );

endmodule

`default_nettype wire

// ==== verilog/ram_1p.sv ====
// Single-port word RAM, always ready, read data one cycle after req
// Address bits above the RAM size are ignored; decode is done by the crossbar

`timescale 1ns/1ps
`default_nettype none

module ram_1p #(
  parameter int unsigned Depth = compliance_pkg::RamSizeWords
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  bus_if.device bus
);

  logic [31:0]              mem [Depth];
  logic [$clog2(Depth)-1:0] word_idx;
  logic [31:0]              rdata_q;
  logic                     rvalid_q;

  assign word_idx = bus.addr[$clog2(Depth)+1:2];

  // Byte lane writes, read returns the word before the write
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (bus.be[lane]) begin
            mem[word_idx][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
          end
        end
      end
      rdata_q <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

`default_nettype wire

// ==== verilog/testutil_dumper.sv ====
// Signature dumper, reads [begin, end) one word at a time over the bus
// Runs once after reset; later start pulses are ignored

`timescale 1ns/1ps
`default_nettype none

module testutil_dumper (
  input  logic        clk_i,
  input  logic        rst_n_i,
  bus_if.host         bus,
  input  logic        start_i,
  input  logic [31:0] sig_begin_i,
  input  logic [31:0] sig_end_i,
  output logic        busy_o,
  output logic        sig_valid_o,
  output logic [31:0] sig_data_o,
  output logic        done_o
);

  import compliance_pkg::*;

  dump_state_e state_q;
  dump_state_e state_d;
  logic [31:0] addr_q;
  logic [31:0] addr_d;
  logic [31:0] end_q;
  logic [31:0] end_d;
  logic [31:0] next_addr;

  assign next_addr = addr_q + 32'd4;

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    end_d   = end_q;
    case (state_q)
      DumpIdle: begin
        if (start_i) begin
          addr_d  = {sig_begin_i[31:2], 2'b00};
          end_d   = sig_end_i;
          state_d = (sig_end_i > sig_begin_i) ? DumpReq : DumpDone;
        end
      end
      DumpReq: begin
        if (bus.gnt) state_d = DumpWait;
      end
      DumpWait: begin
        if (bus.rvalid) begin
          addr_d  = next_addr;
          state_d = (next_addr >= end_q) ? DumpDone : DumpReq;
        end
      end
      default: state_d = DumpDone;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= DumpIdle;
      addr_q  <= 32'h0;
      end_q   <= 32'h0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      end_q   <= end_d;
    end
  end

  // Read-only host with all lanes enabled
  assign bus.req   = (state_q == DumpReq);
  assign bus.addr  = addr_q;
  assign bus.we    = 1'b0;
  assign bus.be    = 4'hF;
  assign bus.wdata = 32'h0;

  assign busy_o      = (state_q == DumpReq) | (state_q == DumpWait);
  assign sig_valid_o = (state_q == DumpWait) & bus.rvalid;
  assign sig_data_o  = bus.rdata;
  assign done_o      = (state_q == DumpDone);

endmodule

`default_nettype wire

// ==== verilog/testutil_regs.sv ====
// Test utility registers: signature bounds and halt trigger
// Offsets outside the register set answer with err; halt writes while busy are dropped

`timescale 1ns/1ps
`default_nettype none

module testutil_regs (
  input  logic        clk_i,
  input  logic        rst_n_i,
  bus_if.device       bus,
  input  logic        busy_i,
  output logic        start_o,
  output logic [31:0] sig_begin_o,
  output logic [31:0] sig_end_o
);

  import compliance_pkg::*;

  tu_reg_e     reg_off;
  logic        reg_valid;
  logic        wr;
  logic [31:0] rd_word;
  logic [31:0] sig_begin_q;
  logic [31:0] sig_end_q;
  logic        start_q;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  function automatic logic [31:0] merge_be(logic [31:0] old_w, logic [31:0] new_w,
                                           logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int lane = 0; lane < 4; lane++) begin
      if (be[lane]) res[lane*8 +: 8] = new_w[lane*8 +: 8];
    end
    return res;
  endfunction

  assign reg_off = tu_reg_e'(bus.addr[7:0]);

  // Only the low 256 bytes of the window hold registers
  always_comb begin
    reg_valid = (bus.addr[9:8] == 2'b00);
    rd_word   = 32'h0;
    case (reg_off)
      RegHalt:     rd_word = {31'h0, busy_i};
      RegSigBegin: rd_word = sig_begin_q;
      RegSigEnd:   rd_word = sig_end_q;
      default:     reg_valid = 1'b0;
    endcase
  end

  assign wr = bus.req & bus.we & reg_valid;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sig_begin_q <= 32'h0;
      sig_end_q   <= 32'h0;
      start_q     <= 1'b0;
      rvalid_q    <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      if (wr && reg_off == RegSigBegin) sig_begin_q <= merge_be(sig_begin_q, bus.wdata, bus.be);
      if (wr && reg_off == RegSigEnd) sig_end_q <= merge_be(sig_end_q, bus.wdata, bus.be);
      // Start is also blocked in the cycle before busy rises
      start_q  <= wr & (reg_off == RegHalt) & ~busy_i & ~start_q;
      rvalid_q <= bus.req;
      err_q    <= bus.req & ~reg_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) rdata_q <= reg_valid ? rd_word : 32'h0;
  end

  assign bus.gnt     = bus.req;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.err     = err_q;
  assign start_o     = start_q;
  assign sig_begin_o = sig_begin_q;
  assign sig_end_o   = sig_end_q;

endmodule

`default_nettype wire
